// File: dv/subset_cache_checker.sv
`timescale 1ns/1ps
`include "subset_cache_params.svh"
`default_nettype none

module subset_cache_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      result_valid,
    input logic                      result_hit,
    input logic [`SC_WAY_BITS:0]     result_position,
    input logic [`SC_COUNT_BITS-1:0] hit_count_4,
    input logic [`SC_COUNT_BITS-1:0] hit_count_8,
    input logic [`SC_COUNT_BITS-1:0] hit_count_16
);

    localparam logic [`SC_WAY_BITS:0] MISS_POS = (`SC_WAY_BITS + 1)'(`SC_WAYS);

    result_idle_after_reset: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("result_valid high in the cycle after reset");

    // a miss and only a miss reports the out-of-stack position
    hit_matches_position: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (result_hit == (result_position != MISS_POS)))
        else $error("result_hit disagrees with result_position");

    counters_monotonic: assert property (@(posedge clk) disable iff (reset)
        (hit_count_4 >= $past(hit_count_4)) && (hit_count_8 >= $past(hit_count_8))
        && (hit_count_16 >= $past(hit_count_16)))
        else $error("a hit counter decreased");

endmodule

bind subset_cache_top subset_cache_checker u_subset_cache_checker (
    .clk             (clk),
    .reset           (reset),
    .result_valid    (result_valid),
    .result_hit      (result_hit),
    .result_position (result_position),
    .hit_count_4     (hit_count_4),
    .hit_count_8     (hit_count_8),
    .hit_count_16    (hit_count_16)
);

`default_nettype wire

// File: dv/subset_cache_tb.sv
`timescale 1ns/1ps
`include "subset_cache_params.svh"
`default_nettype none

module subset_cache_tb;

    localparam logic [31:0] LFSR_SEED = 32'h70f8;
    localparam int MISS = `SC_WAYS;

    logic                      clk;
    logic                      reset;
    logic                      req_valid;
    logic                      req_partition;
    logic [`SC_SET_BITS-1:0]   req_set;
    logic                      req_l2_hit;
    logic [`SC_WAY_BITS:0]     req_hit_way;
    logic                      result_credit;
    logic                      req_credit;
    logic                      result_valid;
    logic                      result_hit;
    logic [`SC_WAY_BITS:0]     result_position;
    logic [`SC_COUNT_BITS-1:0] hit_count_4;
    logic [`SC_COUNT_BITS-1:0] hit_count_8;
    logic [`SC_COUNT_BITS-1:0] hit_count_16;

    // one entry per request, expected values alongside
    logic                    tbl_partition[$];
    logic [`SC_SET_BITS-1:0] tbl_set[$];
    logic                    tbl_l2_hit[$];
    logic [`SC_WAY_BITS:0]   tbl_hit_way[$];
    logic                    tbl_hit[$];
    logic [`SC_WAY_BITS:0]   tbl_position[$];

    int          table_len;
    int          send_idx = 0;
    int          recv_idx = 0;
    int          req_credits = `SC_QUEUE_DEPTH;
    int          credit_wait[$];
    int          exp_4 = 0;
    int          exp_8 = 0;
    int          exp_16 = 0;
    int          cycles = 0;
    int          timeout_limit;
    logic [31:0] lfsr;

    subset_cache_top u_subset_cache_top (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_partition   (req_partition),
        .req_set         (req_set),
        .req_l2_hit      (req_l2_hit),
        .req_hit_way     (req_hit_way),
        .result_credit   (result_credit),
        .req_credit      (req_credit),
        .result_valid    (result_valid),
        .result_hit      (result_hit),
        .result_position (result_position),
        .hit_count_4     (hit_count_4),
        .hit_count_8     (hit_count_8),
        .hit_count_16    (hit_count_16)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        else
            return state >> 1;
    endfunction

    function automatic logic next_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic add_row(input int p, input int s, input int l2, input int hw,
                           input int hit, input int pos);
        tbl_partition.push_back(p[0]);
        tbl_set.push_back(`SC_SET_BITS'(s));
        tbl_l2_hit.push_back(l2[0]);
        tbl_hit_way.push_back((`SC_WAY_BITS + 1)'(hw));
        tbl_hit.push_back(hit[0]);
        tbl_position.push_back((`SC_WAY_BITS + 1)'(pos));
    endtask

    task automatic build_table();
        // empty sets miss even with l2 hit
        add_row(0, 0, 1, 0, 0, MISS);
        add_row(1, 3, 1, 0, 0, MISS);
        // set 1 becomes 1,0,1,0 (front first)
        for (int i = 0; i < 4; i++)
            add_row(i % 2, 1, 0, 0, 0, MISS);
        add_row(1, 1, 1, 1, 1, 2);
        add_row(0, 0, 1, 0, 1, 0);
        add_row(1, 1, 1, 0, 1, 0);
        // l2 miss pushes a second copy, so p0 third entry lands at 4
        add_row(0, 1, 0, 0, 0, MISS);
        add_row(0, 1, 1, 2, 1, 4);
        add_row(1, 1, 1, 2, 0, MISS);
        add_row(1, 3, 1, 0, 1, 0);
        add_row(1, 1, 1, 1, 1, 3);
        // set 2 full of partition 0
        for (int i = 0; i < `SC_WAYS; i++)
            add_row(0, 2, 0, 0, 0, MISS);
        add_row(0, 2, 1, 2, 1, 2);
        add_row(0, 2, 1, 5, 1, 5);
        add_row(0, 2, 1, 12, 1, 12);
        add_row(1, 2, 1, 0, 0, MISS);
        add_row(0, 2, 1, 12, 1, 13);
        add_row(0, 2, 1, 16, 0, MISS);
        add_row(1, 2, 1, 0, 1, 2);
        table_len = tbl_hit.size();
    endtask

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_position(input string name, input logic [`SC_WAY_BITS:0] got,
                                  input logic [`SC_WAY_BITS:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [`SC_COUNT_BITS-1:0] got,
                               input logic [`SC_COUNT_BITS-1:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic take_result();
        int gap;
        if (recv_idx >= table_len)
        begin
            $display("result arrived after the last request was answered");
            abort_run();
        end
        if (credit_wait.size() >= `SC_RESULT_CREDITS)
        begin
            $display("result arrived without a free result credit");
            abort_run();
        end
        check_hit("result_hit", result_hit, tbl_hit[recv_idx]);
        check_position("result_position", result_position, tbl_position[recv_idx]);
        // nested buckets by position
        if (tbl_hit[recv_idx])
        begin
            exp_16++;
            if (int'(tbl_position[recv_idx]) < 8)
                exp_8++;
            if (int'(tbl_position[recv_idx]) < 4)
                exp_4++;
        end
        check_count("hit_count_4", hit_count_4, `SC_COUNT_BITS'(exp_4));
        check_count("hit_count_8", hit_count_8, `SC_COUNT_BITS'(exp_8));
        check_count("hit_count_16", hit_count_16, `SC_COUNT_BITS'(exp_16));
        gap = int'(next_bit());
        gap = gap * 2 + int'(next_bit());
        credit_wait.push_back(gap);
        recv_idx++;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        lfsr          = LFSR_SEED;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_partition = 1'b0;
        req_set       = '0;
        req_l2_hit    = 1'b0;
        req_hit_way   = '0;
        result_credit = 1'b0;
        build_table();
        timeout_limit = 20 * table_len + 100;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait (recv_idx == table_len);
        @(posedge clk);
        check_count("hit_count_4", hit_count_4, `SC_COUNT_BITS'(exp_4));
        check_count("hit_count_8", hit_count_8, `SC_COUNT_BITS'(exp_8));
        check_count("hit_count_16", hit_count_16, `SC_COUNT_BITS'(exp_16));
        $display("SIMULATION PASSED");
        $finish;
    end

    // request side, one send per held credit
    always @(posedge clk)
    begin
        if (reset)
            req_valid <= 1'b0;
        else
        begin
            if (req_credit)
                req_credits = req_credits + 1;
            if (req_credits > `SC_QUEUE_DEPTH)
            begin
                $display("request credit returned without a matching request");
                abort_run();
            end
            if ((send_idx < table_len) && (req_credits > 0))
            begin
                req_valid     <= 1'b1;
                req_partition <= tbl_partition[send_idx];
                req_set       <= tbl_set[send_idx];
                req_l2_hit    <= tbl_l2_hit[send_idx];
                req_hit_way   <= tbl_hit_way[send_idx];
                req_credits = req_credits - 1;
                send_idx = send_idx + 1;
            end
            else
                req_valid <= 1'b0;
        end
    end

    // result side, credits go back after a random gap
    always @(posedge clk)
    begin
        if (reset)
            result_credit <= 1'b0;
        else
        begin
            result_credit <= 1'b0;
            if (result_valid)
                take_result();
            if (credit_wait.size() > 0)
            begin
                if (credit_wait[0] == 0)
                begin
                    result_credit <= 1'b1;
                    void'(credit_wait.pop_front());
                end
                else
                    credit_wait[0] = credit_wait[0] - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > timeout_limit)
        begin
            $display("timeout: only %0d of %0d results arrived", recv_idx, table_len);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: logic/request_queue.sv
`timescale 1ns/1ps
`include "subset_cache_params.svh"
`default_nettype none

module request_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  logic                    req_partition,
    input  logic [`SC_SET_BITS-1:0] req_set,
    input  logic                    req_l2_hit,
    input  logic [`SC_WAY_BITS:0]   req_hit_way,
    input  logic                    q_pop,
    output logic                    q_valid,
    output logic                    q_partition,
    output logic [`SC_SET_BITS-1:0] q_set,
    output logic                    q_l2_hit,
    output logic [`SC_WAY_BITS:0]   q_hit_way,
    output logic                    req_credit
);

    localparam int PTR_BITS = $clog2(`SC_QUEUE_DEPTH);
    localparam int ENTRY_BITS = 1 + `SC_SET_BITS + 1 + `SC_WAY_BITS + 1;

    logic [ENTRY_BITS-1:0] queue_mem [`SC_QUEUE_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [PTR_BITS:0]     count;

    assign q_valid = (count != '0);
    assign {q_partition, q_set, q_l2_hit, q_hit_way} = queue_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (req_valid)
            queue_mem[wr_ptr] <= {req_partition, req_set, req_l2_hit, req_hit_way};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end
        else
        begin
            // credit goes back one cycle after the pop
            req_credit <= q_pop;
            if (req_valid)
                wr_ptr <= (wr_ptr == PTR_BITS'(`SC_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (q_pop)
                rd_ptr <= (rd_ptr == PTR_BITS'(`SC_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({req_valid, q_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/reuse_classifier.sv
`timescale 1ns/1ps
`include "subset_cache_params.svh"
`default_nettype none

module reuse_classifier import subset_cache_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            lk_valid,
    input  logic                            lk_partition,
    input  logic [`SC_SET_BITS-1:0]         lk_set,
    input  logic                            lk_l2_hit,
    input  logic [`SC_WAY_BITS:0]           lk_hit_way,
    input  stack_entry_u [`SC_WAYS-1:0]     lk_stack,
    output logic                            wr_en,
    output logic [`SC_SET_BITS-1:0]         wr_set,
    output stack_entry_u [`SC_WAYS-1:0]     wr_stack,
    output logic                            result_valid,
    output logic                            result_hit,
    output logic [`SC_WAY_BITS:0]           result_position,
    output logic [`SC_COUNT_BITS-1:0]       hit_count_4,
    output logic [`SC_COUNT_BITS-1:0]       hit_count_8,
    output logic [`SC_COUNT_BITS-1:0]       hit_count_16
);

    localparam logic [`SC_WAY_BITS:0] MISS_POS = (`SC_WAY_BITS + 1)'(`SC_WAYS);

    stack_entry_u                want;
    logic                        found;
    logic [`SC_WAY_BITS:0]       match_cnt;
    logic [`SC_WAY_BITS-1:0]     found_idx;
    logic                        hit;
    logic [`SC_WAY_BITS:0]       position;
    stack_entry_u [`SC_WAYS-1:0] new_stack;

    // a valid entry of the requested partition
    always_comb
    begin
        want.fld.valid     = 1'b1;
        want.fld.partition = lk_partition;
    end

    // find the (hit_way+1)-th entry of this partition
    always_comb
    begin
        found     = 1'b0;
        found_idx = '0;
        match_cnt = '0;
        for (int i = 0; i < `SC_WAYS; i++)
        begin
            if (lk_stack[i].code == want.code)
            begin
                if (!found && (match_cnt == lk_hit_way))
                begin
                    found     = 1'b1;
                    found_idx = `SC_WAY_BITS'(i);
                end
                match_cnt = match_cnt + 1'b1;
            end
        end
    end

    assign hit      = lk_l2_hit && found;
    assign position = hit ? {1'b0, found_idx} : MISS_POS;

    // the hit entry equals want, so the front is the same either way.
    // on a miss everything shifts and the last entry drops
    always_comb
    begin
        new_stack[0] = want;
        for (int i = 1; i < `SC_WAYS; i++)
        begin
            if (hit && (i > int'(found_idx)))
                new_stack[i] = lk_stack[i];
            else
                new_stack[i] = lk_stack[i-1];
        end
    end

    assign wr_en    = lk_valid;
    assign wr_set   = lk_set;
    assign wr_stack = new_stack;

    always_ff @(posedge clk)
    begin
        if (lk_valid)
        begin
            result_hit      <= hit;
            result_position <= position;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            hit_count_4  <= '0;
            hit_count_8  <= '0;
            hit_count_16 <= '0;
        end
        else
        begin
            result_valid <= lk_valid;
            if (lk_valid && hit)
            begin
                // nested buckets, smaller caches hit in the larger ones too
                hit_count_16 <= hit_count_16 + 1'b1;
                if (position < (`SC_WAY_BITS + 1)'(8))
                    hit_count_8 <= hit_count_8 + 1'b1;
                if (position < (`SC_WAY_BITS + 1)'(4))
                    hit_count_4 <= hit_count_4 + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/stack_lookup.sv
`timescale 1ns/1ps
`include "subset_cache_params.svh"
`default_nettype none

module stack_lookup import subset_cache_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            q_valid,
    input  logic                            q_partition,
    input  logic [`SC_SET_BITS-1:0]         q_set,
    input  logic                            q_l2_hit,
    input  logic [`SC_WAY_BITS:0]           q_hit_way,
    input  logic                            result_credit,
    input  logic                            wr_en,
    input  logic [`SC_SET_BITS-1:0]         wr_set,
    input  stack_entry_u [`SC_WAYS-1:0]     wr_stack,
    output logic                            q_pop,
    output logic                            lk_valid,
    output logic                            lk_partition,
    output logic [`SC_SET_BITS-1:0]         lk_set,
    output logic                            lk_l2_hit,
    output logic [`SC_WAY_BITS:0]           lk_hit_way,
    output stack_entry_u [`SC_WAYS-1:0]     lk_stack
);

    localparam int SETS = 2 ** `SC_SET_BITS;
    localparam int CREDIT_BITS = $clog2(`SC_RESULT_CREDITS + 1);

    // entry 0 of each stack is the most recent
    stack_entry_u [`SC_WAYS-1:0] stack_mem [SETS];
    logic [CREDIT_BITS-1:0]      credits;

    // spend a result credit at issue
    assign q_pop = q_valid && (credits != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits  <= CREDIT_BITS'(`SC_RESULT_CREDITS);
            lk_valid <= 1'b0;
            for (int s = 0; s < SETS; s++)
                stack_mem[s] <= '0;
        end
        else
        begin
            lk_valid <= q_pop;
            case ({q_pop, result_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (wr_en)
                stack_mem[wr_set] <= wr_stack;
        end
    end

    always_ff @(posedge clk)
    begin
        if (q_pop)
        begin
            lk_partition <= q_partition;
            lk_set       <= q_set;
            lk_l2_hit    <= q_l2_hit;
            lk_hit_way   <= q_hit_way;
            // back-to-back requests to one set see the pending write
            if (wr_en && (wr_set == q_set))
                lk_stack <= wr_stack;
            else
                lk_stack <= stack_mem[q_set];
        end
    end

endmodule

`default_nettype wire

// File: logic/subset_cache_params.svh
`ifndef SUBSET_CACHE_PARAMS_SVH
`define SUBSET_CACHE_PARAMS_SVH

`default_nettype none

// geometry, top bit of the line index picks the partition
`define SC_SET_BITS 4
`define SC_WAYS 16
`define SC_WAY_BITS 4

// hit counter width
`define SC_COUNT_BITS 20

// request fifo depth, also the upstream credit count
`define SC_QUEUE_DEPTH 4
`define SC_RESULT_CREDITS 2

`default_nettype wire

`endif

// File: logic/subset_cache_pkg.sv
`default_nettype none

package subset_cache_pkg;

    // one recency stack entry
    // matched as a raw code, built and inspected through its fields
    typedef union packed {
        logic [1:0] code;
        struct packed {
            logic valid;
            logic partition;
        } fld;
    } stack_entry_u;

endpackage

`default_nettype wire

// File: logic/subset_cache_top.sv
`timescale 1ns/1ps
`include "subset_cache_params.svh"
`default_nettype none

module subset_cache_top import subset_cache_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  logic                      req_partition,
    input  logic [`SC_SET_BITS-1:0]   req_set,
    input  logic                      req_l2_hit,
    input  logic [`SC_WAY_BITS:0]     req_hit_way,
    input  logic                      result_credit,
    output logic                      req_credit,
    output logic                      result_valid,
    output logic                      result_hit,
    output logic [`SC_WAY_BITS:0]     result_position,
    output logic [`SC_COUNT_BITS-1:0] hit_count_4,
    output logic [`SC_COUNT_BITS-1:0] hit_count_8,
    output logic [`SC_COUNT_BITS-1:0] hit_count_16
);

    logic                        q_valid;
    logic                        q_partition;
    logic [`SC_SET_BITS-1:0]     q_set;
    logic                        q_l2_hit;
    logic [`SC_WAY_BITS:0]       q_hit_way;
    logic                        q_pop;

    logic                        lk_valid;
    logic                        lk_partition;
    logic [`SC_SET_BITS-1:0]     lk_set;
    logic                        lk_l2_hit;
    logic [`SC_WAY_BITS:0]       lk_hit_way;
    stack_entry_u [`SC_WAYS-1:0] lk_stack;

    logic                        wr_en;
    logic [`SC_SET_BITS-1:0]     wr_set;
    stack_entry_u [`SC_WAYS-1:0] wr_stack;

    request_queue u_request_queue (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_partition (req_partition),
        .req_set       (req_set),
        .req_l2_hit    (req_l2_hit),
        .req_hit_way   (req_hit_way),
        .q_pop         (q_pop),
        .q_valid       (q_valid),
        .q_partition   (q_partition),
        .q_set         (q_set),
        .q_l2_hit      (q_l2_hit),
        .q_hit_way     (q_hit_way),
        .req_credit    (req_credit)
    );

    stack_lookup u_stack_lookup (
        .clk           (clk),
        .reset         (reset),
        .q_valid       (q_valid),
        .q_partition   (q_partition),
        .q_set         (q_set),
        .q_l2_hit      (q_l2_hit),
        .q_hit_way     (q_hit_way),
        .result_credit (result_credit),
        .wr_en         (wr_en),
        .wr_set        (wr_set),
        .wr_stack      (wr_stack),
        .q_pop         (q_pop),
        .lk_valid      (lk_valid),
        .lk_partition  (lk_partition),
        .lk_set        (lk_set),
        .lk_l2_hit     (lk_l2_hit),
        .lk_hit_way    (lk_hit_way),
        .lk_stack      (lk_stack)
    );

    reuse_classifier u_reuse_classifier (
        .clk             (clk),
        .reset           (reset),
        .lk_valid        (lk_valid),
        .lk_partition    (lk_partition),
        .lk_set          (lk_set),
        .lk_l2_hit       (lk_l2_hit),
        .lk_hit_way      (lk_hit_way),
        .lk_stack        (lk_stack),
        .wr_en           (wr_en),
        .wr_set          (wr_set),
        .wr_stack        (wr_stack),
        .result_valid    (result_valid),
        .result_hit      (result_hit),
        .result_position (result_position),
        .hit_count_4     (hit_count_4),
        .hit_count_8     (hit_count_8),
        .hit_count_16    (hit_count_16)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the subset cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module subset_cache_tb \
    -Mdir obj_dir

./obj_dir/Vsubset_cache_tb | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run failed"
    exit 1
fi
echo "run passed"

// File: tb.f
+incdir+logic
logic/subset_cache_pkg.sv
logic/request_queue.sv
logic/stack_lookup.sv
logic/reuse_classifier.sv
logic/subset_cache_top.sv
dv/subset_cache_checker.sv
dv/subset_cache_tb.sv
